/* include/rv_cfg.svh */
// Encodes only the supported RV32I subset and assumes a 32-bit word with 32 registers
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Core sizing
`define RV_XLEN      32
`define RV_NREGS     32
`define RV_RESET_PC  32'h0000_0000

// ------------------------------
// Major opcodes
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_OPIMM  7'b0010011
`define RV_OP_OP     7'b0110011

// ------------------------------
// funct3 codes
`define RV_F3_ADD_SUB 3'b000
`define RV_F3_SLL     3'b001
`define RV_F3_SLT     3'b010
`define RV_F3_XOR     3'b100
`define RV_F3_SRL     3'b101
`define RV_F3_OR      3'b110
`define RV_F3_AND     3'b111
`define RV_F3_BEQ     3'b000
`define RV_F3_BNE     3'b001
`define RV_F3_LW      3'b010
`define RV_F3_SW      3'b010

`endif

/* source/rv_pkg.sv */
// Types follow the widths in rv_cfg.svh and the ALU covers only the supported RV32I subset
`include "rv_cfg.svh"

package rv_pkg;

	// Data value, byte address or instruction
	typedef logic [`RV_XLEN-1:0] word_t;

	typedef logic [$clog2(`RV_NREGS)-1:0] reg_idx_t;

	// Word address on a memory port
	typedef logic [`RV_XLEN-3:0] waddr_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL
	} alu_op_t;

	// Operand source in EX
	typedef enum logic [1:0] {
		FWD_NONE = 2'd0,
		FWD_MEM  = 2'd1,
		FWD_WB   = 2'd2
	} fwd_sel_t;

endpackage

/* source/rv_fetch.sv */
// Expects the instruction memory to answer in the same cycle that the address is shown
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_fetch (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           mem_stall,
	input  logic           stall_id,
	input  logic           flush,
	input  logic           redirect,
	input  rv_pkg::word_t  target,
	input  rv_pkg::word_t  imem_rdata,
	output rv_pkg::waddr_t imem_addr,
	output rv_pkg::word_t  id_pc,
	output rv_pkg::word_t  id_instr
);
	import rv_pkg::*;

	word_t pc;
	word_t pc_next;

	// Redirect from EX wins over a load-use hold
	always_comb begin
		if (redirect) begin
			pc_next = target;
		end else if (stall_id) begin
			pc_next = pc;
		end else begin
			pc_next = pc + word_t'(4);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= `RV_RESET_PC;
		end else if (!mem_stall) begin
			pc <= pc_next;
		end
	end

	// ------------------------------
	// IF/ID register
	// Zero word decodes as a no-op
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			id_instr <= '0;
		end else if (!mem_stall) begin
			if (flush) begin
				id_instr <= '0;
			end else if (!stall_id) begin
				id_instr <= imem_rdata;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!mem_stall && !stall_id) begin
			id_pc <= pc;
		end
	end

	assign imem_addr = waddr_t'(pc >> 2);

endmodule

/* source/rv_decode.sv */
// Decodes only the supported RV32I subset and unknown encodings come out as a no-op
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_decode (
	input  rv_pkg::word_t    instr,
	output rv_pkg::reg_idx_t rs1,
	output rv_pkg::reg_idx_t rs2,
	output rv_pkg::reg_idx_t rd,
	output rv_pkg::word_t    imm,
	output rv_pkg::alu_op_t  alu_op,
	output logic             alu_src_imm,
	output logic             mem_read,
	output logic             mem_write,
	output logic             reg_write,
	output logic             branch,
	output logic             jal,
	output logic             jalr
);
	import rv_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_j;
	alu_op_t    arith_op;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign rd     = instr[11:7];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];

	// Immediate formats
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// Shared by register and immediate ALU forms
	always_comb begin
		case (funct3)
			`RV_F3_ADD_SUB: arith_op = (opcode == `RV_OP_OP && instr[30]) ? ALU_SUB : ALU_ADD;
			`RV_F3_SLL:     arith_op = ALU_SLL;
			`RV_F3_SLT:     arith_op = ALU_SLT;
			`RV_F3_XOR:     arith_op = ALU_XOR;
			`RV_F3_SRL:     arith_op = ALU_SRL;
			`RV_F3_OR:      arith_op = ALU_OR;
			`RV_F3_AND:     arith_op = ALU_AND;
			default:        arith_op = ALU_ADD;
		endcase
	end

	// ------------------------------
	// Control levels
	always_comb begin
		imm         = '0;
		alu_op      = ALU_ADD;
		alu_src_imm = 1'b0;
		mem_read    = 1'b0;
		mem_write   = 1'b0;
		reg_write   = 1'b0;
		branch      = 1'b0;
		jal         = 1'b0;
		jalr        = 1'b0;
		case (opcode)
			`RV_OP_OP: begin
				reg_write = 1'b1;
				alu_op    = arith_op;
			end
			`RV_OP_OPIMM: begin
				reg_write   = 1'b1;
				alu_src_imm = 1'b1;
				alu_op      = arith_op;
				imm         = imm_i;
			end
			`RV_OP_LOAD: begin
				mem_read    = (funct3 == `RV_F3_LW);
				reg_write   = (funct3 == `RV_F3_LW);
				alu_src_imm = 1'b1;
				imm         = imm_i;
			end
			`RV_OP_STORE: begin
				mem_write   = (funct3 == `RV_F3_SW);
				alu_src_imm = 1'b1;
				imm         = imm_s;
			end
			`RV_OP_BRANCH: begin
				// EX reads the taken sense from the ALU op
				branch = (funct3 == `RV_F3_BEQ) || (funct3 == `RV_F3_BNE);
				alu_op = (funct3 == `RV_F3_BEQ) ? ALU_SUB : ALU_XOR;
				imm    = imm_b;
			end
			`RV_OP_JAL: begin
				jal       = 1'b1;
				reg_write = 1'b1;
				imm       = imm_j;
			end
			`RV_OP_JALR: begin
				jalr        = 1'b1;
				reg_write   = 1'b1;
				alu_src_imm = 1'b1;
				imm         = imm_i;
			end
			default: begin
			end
		endcase
	end

endmodule

/* source/rv_regfile.sv */
// Writes land at the clock edge and a same-cycle read of the written index sees the new value
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_regfile (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             we,
	input  rv_pkg::reg_idx_t waddr,
	input  rv_pkg::reg_idx_t raddr1,
	input  rv_pkg::reg_idx_t raddr2,
	input  rv_pkg::word_t    wdata,
	output rv_pkg::word_t    rdata1,
	output rv_pkg::word_t    rdata2
);
	import rv_pkg::*;

	word_t regs [`RV_NREGS];

	// Entry 0 is never written
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `RV_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// x0 first then write bypass then array
	assign rdata1 = (raddr1 == '0) ? '0 :
		(we && waddr == raddr1) ? wdata : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 :
		(we && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

/* source/rv_hazard.sv */
// Only a load in EX stalls ID and a redirect always flushes the two younger slots
`timescale 1ns/1ns

module rv_hazard (
	input  rv_pkg::reg_idx_t id_rs1,
	input  rv_pkg::reg_idx_t id_rs2,
	input  rv_pkg::reg_idx_t ex_rd,
	input  logic             ex_mem_read,
	input  rv_pkg::reg_idx_t ex_rs1,
	input  rv_pkg::reg_idx_t ex_rs2,
	input  rv_pkg::reg_idx_t mem_rd,
	input  rv_pkg::reg_idx_t wb_rd,
	input  logic             mem_reg_write,
	input  logic             wb_reg_write,
	input  logic             redirect,
	output logic             stall_id,
	output logic             flush,
	output rv_pkg::fwd_sel_t fwd_a,
	output rv_pkg::fwd_sel_t fwd_b
);
	import rv_pkg::*;

	// Youngest producer wins
	function automatic fwd_sel_t pick(input reg_idx_t src, input reg_idx_t m_rd,
		input logic m_we, input reg_idx_t w_rd, input logic w_we);
		fwd_sel_t sel;
		sel = FWD_NONE;
		if (m_we && m_rd != '0 && m_rd == src) begin
			sel = FWD_MEM;
		end else if (w_we && w_rd != '0 && w_rd == src) begin
			sel = FWD_WB;
		end
		return sel;
	endfunction

	assign fwd_a = pick(ex_rs1, mem_rd, mem_reg_write, wb_rd, wb_reg_write);
	assign fwd_b = pick(ex_rs2, mem_rd, mem_reg_write, wb_rd, wb_reg_write);

	// Load result not ready until it reaches WB
	assign stall_id = ex_mem_read && (ex_rd != '0) &&
		((ex_rd == id_rs1) || (ex_rd == id_rs2));

	assign flush = redirect;

endmodule

/* source/rv_execute.sv */
// Branches and jumps resolve here so a taken one costs two flushed slots
`timescale 1ns/1ns

module rv_execute (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             mem_stall,
	input  logic             stall_id,
	input  logic             flush,
	input  rv_pkg::word_t    id_pc,
	input  rv_pkg::reg_idx_t rs1,
	input  rv_pkg::reg_idx_t rs2,
	input  rv_pkg::reg_idx_t rd,
	input  rv_pkg::word_t    imm,
	input  rv_pkg::alu_op_t  alu_op,
	input  logic             alu_src_imm,
	input  logic             mem_read,
	input  logic             mem_write,
	input  logic             reg_write,
	input  logic             branch,
	input  logic             jal,
	input  logic             jalr,
	input  rv_pkg::word_t    rdata1,
	input  rv_pkg::word_t    rdata2,
	input  rv_pkg::fwd_sel_t fwd_a,
	input  rv_pkg::fwd_sel_t fwd_b,
	input  rv_pkg::word_t    mem_result,
	input  rv_pkg::word_t    wb_value,
	output rv_pkg::reg_idx_t ex_rs1,
	output rv_pkg::reg_idx_t ex_rs2,
	output rv_pkg::reg_idx_t ex_rd,
	output logic             ex_mem_read,
	output logic             redirect,
	output rv_pkg::word_t    target,
	output rv_pkg::word_t    ex_result,
	output rv_pkg::word_t    ex_store_data,
	output logic             ex_reg_write,
	output logic             ex_mem_write
);
	import rv_pkg::*;

	word_t   ex_pc;
	word_t   ex_imm;
	word_t   ex_data1;
	word_t   ex_data2;
	alu_op_t ex_alu_op;
	logic    ex_src_imm;
	logic    ex_branch;
	logic    ex_jal;
	logic    ex_jalr;
	logic    bubble;
	word_t   op_a;
	word_t   op_b;
	word_t   alu_out;
	logic    take_branch;

	assign bubble = stall_id || flush;

	// ------------------------------
	// ID/EX register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_mem_read  <= 1'b0;
			ex_mem_write <= 1'b0;
			ex_reg_write <= 1'b0;
			ex_branch    <= 1'b0;
			ex_jal       <= 1'b0;
			ex_jalr      <= 1'b0;
		end else if (!mem_stall) begin
			ex_mem_read  <= mem_read && !bubble;
			ex_mem_write <= mem_write && !bubble;
			ex_reg_write <= reg_write && !bubble;
			ex_branch    <= branch && !bubble;
			ex_jal       <= jal && !bubble;
			ex_jalr      <= jalr && !bubble;
		end
	end

	always_ff @(posedge clk) begin
		if (!mem_stall) begin
			ex_pc      <= id_pc;
			ex_imm     <= imm;
			ex_data1   <= rdata1;
			ex_data2   <= rdata2;
			ex_rs1     <= rs1;
			ex_rs2     <= rs2;
			ex_rd      <= rd;
			ex_alu_op  <= alu_op;
			ex_src_imm <= alu_src_imm;
		end
	end

	// Operand forwarding
	always_comb begin
		case (fwd_a)
			FWD_MEM: op_a = mem_result;
			FWD_WB:  op_a = wb_value;
			default: op_a = ex_data1;
		endcase
		case (fwd_b)
			FWD_MEM: ex_store_data = mem_result;
			FWD_WB:  ex_store_data = wb_value;
			default: ex_store_data = ex_data2;
		endcase
	end

	assign op_b = ex_src_imm ? ex_imm : ex_store_data;

	always_comb begin
		case (ex_alu_op)
			ALU_SUB: alu_out = op_a - op_b;
			ALU_AND: alu_out = op_a & op_b;
			ALU_OR:  alu_out = op_a | op_b;
			ALU_XOR: alu_out = op_a ^ op_b;
			ALU_SLT: alu_out = ($signed(op_a) < $signed(op_b)) ? word_t'(1) : '0;
			ALU_SLL: alu_out = op_a << op_b[4:0];
			ALU_SRL: alu_out = op_a >> op_b[4:0];
			default: alu_out = op_a + op_b;
		endcase
	end

	// BEQ runs as SUB and BNE as XOR so a zero result means taken only for BEQ
	assign take_branch = ex_branch && ((ex_alu_op == ALU_SUB) == (alu_out == '0));
	assign redirect    = take_branch || ex_jal || ex_jalr;

	// JALR target has bit 0 cleared
	assign target    = ex_jalr ? (alu_out & ~word_t'(1)) : ex_pc + ex_imm;
	assign ex_result = (ex_jal || ex_jalr) ? ex_pc + word_t'(4) : alu_out;

endmodule

/* source/rv_mem_wb.sv */
// Data memory must answer in the same cycle and an access counts only in a cycle without mem_stall
`timescale 1ns/1ns

module rv_mem_wb (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             mem_stall,
	input  rv_pkg::word_t    ex_result,
	input  rv_pkg::word_t    ex_store_data,
	input  rv_pkg::reg_idx_t ex_rd,
	input  logic             ex_reg_write,
	input  logic             ex_mem_read,
	input  logic             ex_mem_write,
	input  rv_pkg::word_t    dmem_rdata,
	output logic             dmem_ren,
	output logic             dmem_wen,
	output rv_pkg::waddr_t   dmem_addr,
	output rv_pkg::word_t    dmem_wdata,
	output rv_pkg::word_t    mem_result,
	output rv_pkg::reg_idx_t mem_rd,
	output logic             mem_reg_write,
	output rv_pkg::word_t    wb_value,
	output rv_pkg::reg_idx_t wb_rd,
	output logic             wb_we
);
	import rv_pkg::*;

	word_t mem_store_data;
	word_t wb_alu;
	word_t wb_load;
	logic  wb_is_load;
	logic  wb_reg_write;

	// ------------------------------
	// EX/MEM register drives the data port
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dmem_ren      <= 1'b0;
			dmem_wen      <= 1'b0;
			mem_reg_write <= 1'b0;
		end else if (!mem_stall) begin
			dmem_ren      <= ex_mem_read;
			dmem_wen      <= ex_mem_write;
			mem_reg_write <= ex_reg_write;
		end
	end

	always_ff @(posedge clk) begin
		if (!mem_stall) begin
			mem_result     <= ex_result;
			mem_store_data <= ex_store_data;
			mem_rd         <= ex_rd;
		end
	end

	assign dmem_addr  = waddr_t'(mem_result >> 2);
	assign dmem_wdata = mem_store_data;

	// ------------------------------
	// MEM/WB register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_reg_write <= 1'b0;
			wb_is_load   <= 1'b0;
		end else if (!mem_stall) begin
			wb_reg_write <= mem_reg_write;
			wb_is_load   <= dmem_ren;
		end
	end

	// load data sampled in the accepting cycle
	always_ff @(posedge clk) begin
		if (!mem_stall) begin
			wb_alu  <= mem_result;
			wb_load <= dmem_rdata;
			wb_rd   <= mem_rd;
		end
	end

	assign wb_value = wb_is_load ? wb_load : wb_alu;

	// Register file must not change while frozen
	assign wb_we = wb_reg_write && !mem_stall;

endmodule

/* source/rv_core.sv */
// Both memories are combinational word ports and mem_stall freezes the whole pipeline
`timescale 1ns/1ns

module rv_core (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           mem_stall,
	output rv_pkg::waddr_t imem_addr,
	input  rv_pkg::word_t  imem_rdata,
	output logic           dmem_ren,
	output logic           dmem_wen,
	output rv_pkg::waddr_t dmem_addr,
	output rv_pkg::word_t  dmem_wdata,
	input  rv_pkg::word_t  dmem_rdata
);
	import rv_pkg::*;

	word_t    id_pc, id_instr, id_imm, rdata1, rdata2, target;
	word_t    ex_result, ex_store_data, mem_result, wb_value;
	reg_idx_t id_rs1, id_rs2, id_rd, ex_rs1, ex_rs2, ex_rd, mem_rd, wb_rd;
	alu_op_t  id_alu_op;
	fwd_sel_t fwd_a, fwd_b;
	logic     id_alu_src_imm, id_mem_read, id_mem_write, id_reg_write;
	logic     id_branch, id_jal, id_jalr;
	logic     stall_id, flush, redirect;
	logic     ex_mem_read, ex_mem_write, ex_reg_write, mem_reg_write, wb_we;

	rv_fetch u_fetch (
		.clk(clk), .rst_n(rst_n), .mem_stall(mem_stall), .stall_id(stall_id),
		.flush(flush), .redirect(redirect), .target(target), .imem_rdata(imem_rdata),
		.imem_addr(imem_addr), .id_pc(id_pc), .id_instr(id_instr)
	);

	rv_decode u_decode (
		.instr(id_instr), .rs1(id_rs1), .rs2(id_rs2), .rd(id_rd), .imm(id_imm),
		.alu_op(id_alu_op), .alu_src_imm(id_alu_src_imm), .mem_read(id_mem_read),
		.mem_write(id_mem_write), .reg_write(id_reg_write), .branch(id_branch),
		.jal(id_jal), .jalr(id_jalr)
	);

	rv_regfile u_regfile (
		.clk(clk), .rst_n(rst_n), .we(wb_we), .waddr(wb_rd), .raddr1(id_rs1),
		.raddr2(id_rs2), .wdata(wb_value), .rdata1(rdata1), .rdata2(rdata2)
	);

	rv_hazard u_hazard (
		.id_rs1(id_rs1), .id_rs2(id_rs2), .ex_rd(ex_rd), .ex_mem_read(ex_mem_read),
		.ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .mem_rd(mem_rd), .wb_rd(wb_rd),
		.mem_reg_write(mem_reg_write), .wb_reg_write(wb_we), .redirect(redirect),
		.stall_id(stall_id), .flush(flush), .fwd_a(fwd_a), .fwd_b(fwd_b)
	);

	rv_execute u_execute (
		.clk(clk), .rst_n(rst_n), .mem_stall(mem_stall), .stall_id(stall_id),
		.flush(flush), .id_pc(id_pc), .rs1(id_rs1), .rs2(id_rs2), .rd(id_rd),
		.imm(id_imm), .alu_op(id_alu_op), .alu_src_imm(id_alu_src_imm),
		.mem_read(id_mem_read), .mem_write(id_mem_write), .reg_write(id_reg_write),
		.branch(id_branch), .jal(id_jal), .jalr(id_jalr), .rdata1(rdata1),
		.rdata2(rdata2), .fwd_a(fwd_a), .fwd_b(fwd_b), .mem_result(mem_result),
		.wb_value(wb_value), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rd(ex_rd),
		.ex_mem_read(ex_mem_read), .redirect(redirect), .target(target),
		.ex_result(ex_result), .ex_store_data(ex_store_data),
		.ex_reg_write(ex_reg_write), .ex_mem_write(ex_mem_write)
	);

	rv_mem_wb u_mem_wb (
		.clk(clk), .rst_n(rst_n), .mem_stall(mem_stall), .ex_result(ex_result),
		.ex_store_data(ex_store_data), .ex_rd(ex_rd), .ex_reg_write(ex_reg_write),
		.ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write), .dmem_rdata(dmem_rdata),
		.dmem_ren(dmem_ren), .dmem_wen(dmem_wen), .dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata), .mem_result(mem_result), .mem_rd(mem_rd),
		.mem_reg_write(mem_reg_write), .wb_value(wb_value), .wb_rd(wb_rd), .wb_we(wb_we)
	);

endmodule

/* sim/rv_checker.sv */
// Samples the core ports at the rising edge and holds no state beyond the previous sample
`timescale 1ns/1ns

module rv_checker (
	input logic           clk,
	input logic           rst_n,
	input logic           mem_stall,
	input rv_pkg::waddr_t imem_addr,
	input logic           dmem_ren,
	input logic           dmem_wen,
	input rv_pkg::waddr_t dmem_addr,
	input rv_pkg::word_t  dmem_wdata
);
	import rv_pkg::*;

	// ------------------------------
	// Port protocol
	a_quiet_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> (!dmem_ren && !dmem_wen))
		else $error("data port strobes active in the first cycle after reset");

	a_no_read_write: assert property (@(posedge clk) disable iff (!rst_n)
		!(dmem_ren && dmem_wen))
		else $error("dmem_ren and dmem_wen high together");

	// Frozen pipeline keeps every output
	a_stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
		mem_stall |=> ($stable(imem_addr) && $stable(dmem_ren) && $stable(dmem_wen)
			&& $stable(dmem_addr) && $stable(dmem_wdata)))
		else $error("core outputs changed while mem_stall was high");

endmodule

bind rv_core rv_checker chk0 (
	.clk(clk), .rst_n(rst_n), .mem_stall(mem_stall), .imem_addr(imem_addr),
	.dmem_ren(dmem_ren), .dmem_wen(dmem_wen), .dmem_addr(dmem_addr),
	.dmem_wdata(dmem_wdata)
);

/* sim/rv_tb.sv */
// Runs from the project root, program fits 64 words and data memory holds 512 words
`timescale 1ns/1ns

module rv_tb;
	import rv_pkg::*;

	localparam int IMEM_WORDS = 64;
	localparam int DMEM_WORDS = 512;
	localparam logic [29:0] MARKER_ADDR = 30'h1ff;

	logic   clk = 1'b0;
	logic   rst_n = 1'b0;
	logic   mem_stall = 1'b0;
	logic   stall_on = 1'b0;
	logic   [31:0] lfsr = 32'he65fd3bf;
	waddr_t imem_addr;
	word_t  imem_rdata;
	logic   dmem_ren;
	logic   dmem_wen;
	waddr_t dmem_addr;
	word_t  dmem_wdata;
	word_t  dmem_rdata;

	word_t  imem [IMEM_WORDS];
	word_t  dmem [DMEM_WORDS];
	string  exp_name [$];
	word_t  exp_addr [$];
	word_t  exp_data [$];
	int     n_words = 0;
	int     exp_idx = 0;
	int     errors = 0;
	int     test_errors = 0;
	int     tests_run = 0;
	int     tests_failed = 0;
	logic   pass_done = 1'b0;
	logic   loaded = 1'b0;
	string  pass_label = "plain";

	rv_core dut0 (
		.clk(clk), .rst_n(rst_n), .mem_stall(mem_stall), .imem_addr(imem_addr),
		.imem_rdata(imem_rdata), .dmem_ren(dmem_ren), .dmem_wen(dmem_wen),
		.dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata)
	);

	always #10 clk = ~clk;

	// Fibonacci taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// ------------------------------
	// Memory models
	assign imem_rdata = (imem_addr[29:6] == '0) ? imem[imem_addr[5:0]] : '0;
	// Read data only while the core requests a load
	assign dmem_rdata = (dmem_ren && dmem_addr[29:9] == '0) ? dmem[dmem_addr[8:0]] : '0;

	always @(negedge clk) begin
		if (stall_on) begin
			lfsr = lfsr_step(lfsr);
			mem_stall = lfsr[0];
		end else begin
			mem_stall = 1'b0;
		end
	end

	task automatic compare_value(input string name, input string what,
		input word_t expected, input word_t actual);
		if (expected !== actual) begin
			$display("Error: test %s/%s %s expected %h actual %h",
				pass_label, name, what, expected, actual);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_store();
		string name;
		if (exp_idx >= exp_name.size()) begin
			$display("Unexpected store to word %h after the last expected one", dmem_addr);
			errors++;
		end else begin
			name = exp_name[exp_idx];
			compare_value(name, "address", exp_addr[exp_idx], word_t'(dmem_addr));
			compare_value(name, "data", exp_data[exp_idx], dmem_wdata);
			exp_idx++;
			if (exp_idx == exp_name.size() || exp_name[exp_idx] != name) begin
				tests_run++;
				if (test_errors != 0) begin
					tests_failed++;
				end
				$display("%s/%s: %s", pass_label, name, (test_errors == 0) ? "ok" : "mismatch");
				test_errors = 0;
			end
		end
		if (dmem_addr == MARKER_ADDR) begin
			pass_done = 1'b1;
		end
	endtask

	// Store acceptance uses the values from before this edge
	always @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < DMEM_WORDS; i++) begin
				dmem[i] <= {23'h4d2a6b, i[8:0]};
			end
			exp_idx = 0;
			test_errors = 0;
			pass_done = 1'b0;
		end else if (dmem_wen && !mem_stall) begin
			if (dmem_addr[29:9] != '0) begin
				$display("Store to word %h falls outside the data memory", dmem_addr);
				errors++;
			end else begin
				dmem[dmem_addr[8:0]] <= dmem_wdata;
			end
			check_store();
		end
	end

	task automatic load_vectors();
		int    fd;
		string line;
		string tag;
		string name;
		word_t v0;
		word_t v1;
		for (int i = 0; i < IMEM_WORDS; i++) begin
			imem[i] = '0;
		end
		fd = $fopen("sim/rv_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open the vector file sim/rv_vectors.txt");
			errors++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			tag = "";
			void'($sscanf(line, "%s", tag));
			if (tag == "P" && n_words < IMEM_WORDS) begin
				if ($sscanf(line, "%s %h", tag, v0) == 2) begin
					imem[n_words] = v0;
					n_words++;
				end
			end else if (tag == "S") begin
				if ($sscanf(line, "%s %s %h %h", tag, name, v0, v1) == 4) begin
					exp_name.push_back(name);
					exp_addr.push_back(v0);
					exp_data.push_back(v1);
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic run_pass(input logic with_stall, input string label);
		@(negedge clk);
		rst_n = 1'b0;
		pass_label = label;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		@(posedge clk);
		stall_on = with_stall;
		wait (pass_done);
		stall_on = 1'b0;
		// Idle edges after the marker expose a repeated store
		repeat (4) @(negedge clk);
	endtask

	// Eight cycles per program word per pass, two passes
	initial begin
		wait (loaded);
		repeat (n_words * 8 * 2 + 8) @(posedge clk);
		$display("Timeout: the end marker store was not seen in time");
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		load_vectors();
		loaded = 1'b1;
		if (errors == 0) begin
			run_pass(1'b0, "plain");
			run_pass(1'b1, "stall_pass");
		end
		$display("Tests run %0d, tests failed %0d, mismatches %0d",
			tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* sim/rv_vectors.txt */
# P <instruction hex> : program word, in address order from the reset PC
# S <test name> <store word address hex> <store data hex> : expected store, in issue order
P 00500093
P ffd00113
P 402081b3
P 00112233
P 004092b3
P 00115333
P 10302023
P 10402223
P 10502423
P 10602623
P 00308393
P 0013c433
P 00140013
P 000464b3
P 10902823
P 10002503
P 00750593
P 10b02a23
P 00708463
P 00100613
P 00709463
P 06300613
P 008006ef
P 04d00613
P 06d00767
P 03700613
P 02c00613
P 10c02c23
P 10d02e23
P 12e02023
P 7e102e23
P 0000006f
S alu_ops 040 00000008
S alu_ops 041 00000001
S alu_ops 042 0000000a
S alu_ops 043 07ffffff
S forwarding 044 0000000d
S load_use 045 0000000f
S control_flow 046 00000001
S control_flow 047 0000005c
S control_flow 048 00000064
S end_marker 1ff 00000005

/* tb.f */
+incdir+include
source/rv_pkg.sv
source/rv_fetch.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_hazard.sv
source/rv_execute.sv
source/rv_mem_wb.sv
source/rv_core.sv
sim/rv_checker.sv
sim/rv_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module rv_tb -Mdir obj_dir -o rv_sim
./obj_dir/rv_sim 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
grep -q "TEST OK" sim.log
